/* design/segway_pkg.sv */
`default_nettype none

package segway_pkg;

  ////////////////////////////////////////////////////////////
  // vector types with a meaning
  ////////////////////////////////////////////////////////////
  typedef logic signed [11:0] duty_t;       // signed motor duty, fwd count - rev count
  typedef logic [10:0]        pwm_cnt_t;    // pwm high time in clk cycles
  typedef logic [11:0]        watchdog_t;   // msb set -> 2048 cycles elapsed
  typedef logic signed [15:0] torque_t;     // rider lean / motor / net torque
  typedef logic signed [15:0] plat_state_t; // omega, theta, az, pitch rate
  typedef logic [6:0]         reg_addr_t;   // sensor register address
  typedef logic [7:0]         reg_byte_t;   // sensor register data
  typedef logic [15:0]        spi_word_t;   // one full spi frame

  ////////////////////////////////////////////////////////////
  // torque curve and sensor scaling
  ////////////////////////////////////////////////////////////
  localparam logic [11:0]        min_duty        = 12'h3D4;  // top of dead zone
  localparam logic [15:0]        torque_gain     = 16'd14;   // slope past dead zone
  localparam plat_state_t        ptch_rt_offset  = 16'h03C2; // gyro zero offset
  localparam plat_state_t        az_offset       = 16'hFE80; // accel zero offset
  localparam logic signed [4:0]  ptch_rate_scale = 5'sd12;   // /16 applied later

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////
  localparam reg_addr_t addr_ptch_lo = 7'h22; // read clears int
  localparam reg_addr_t addr_ptch_hi = 7'h23;
  localparam reg_addr_t addr_az_lo   = 7'h2C;
  localparam reg_addr_t addr_az_hi   = 7'h2D;
  localparam reg_addr_t addr_cfg_a   = 7'h0D;
  localparam reg_byte_t cfg_a_value  = 8'h02;
  localparam reg_addr_t addr_cfg_b   = 7'h11;
  localparam reg_byte_t cfg_b_value  = 8'h50;

  localparam reg_byte_t write_response = 8'hA5; // second byte of every write

  // output data rate timing
  localparam int odr_prescale = 4;  // clk cycles per odr tick
  localparam int odr_bits     = 11; // odr counter width
  localparam int odr_pre_bits = $clog2(odr_prescale);
  localparam logic [odr_pre_bits-1:0] odr_pre_last = odr_pre_bits'(odr_prescale - 1);

endpackage

`default_nettype wire

/* design/spi_slave_port.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave_port (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   ss_n,
  input  wire                   sclk,
  input  wire                   mosi,
  input  wire segway_pkg::reg_byte_t rsp_byte,   // response for the second byte
  output logic                  miso,
  output logic                  cmd_strobe,      // first byte complete
  output segway_pkg::reg_byte_t cmd_byte,
  output logic                  wr_strobe,       // frame ended, commit write
  output segway_pkg::reg_addr_t wr_addr,
  output segway_pkg::reg_byte_t wr_data
);

  logic sclk_ff1, sclk_ff2, sclk_ff3;   // 2-flop sync + edge detect stage
  logic ss_ff1, ss_ff2, ss_ff3;
  logic mosi_ff1, mosi_ff2;             // kept in step with sclk sync
  logic sclk_rise, sclk_fall;
  logic ss_fall, ss_rise;
  logic [3:0] bit_cnt;                  // sampled bits in this frame
  segway_pkg::spi_word_t rx_sr;         // receive shift register
  segway_pkg::reg_byte_t tx_sr;         // transmit shift register
  logic miso_q;
  logic wr_pend;                        // full write frame seen

  ////////////////////////////////////////////////////////////
  // pin synchronizers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_ff1 <= 1'b0;   // mode 0, sclk idles low
      sclk_ff2 <= 1'b0;
      sclk_ff3 <= 1'b0;
      ss_ff1   <= 1'b1;   // deselected
      ss_ff2   <= 1'b1;
      ss_ff3   <= 1'b1;
      mosi_ff1 <= 1'b0;
      mosi_ff2 <= 1'b0;
    end else begin
      sclk_ff1 <= sclk;
      sclk_ff2 <= sclk_ff1;
      sclk_ff3 <= sclk_ff2;
      ss_ff1   <= ss_n;
      ss_ff2   <= ss_ff1;
      ss_ff3   <= ss_ff2;
      mosi_ff1 <= mosi;
      mosi_ff2 <= mosi_ff1;
    end
  end

  assign sclk_rise = sclk_ff2 & ~sclk_ff3;
  assign sclk_fall = ~sclk_ff2 & sclk_ff3;
  assign ss_fall   = ~ss_ff2 & ss_ff3;   // frame start
  assign ss_rise   = ss_ff2 & ~ss_ff3;   // frame end

  // bit counter and byte/frame strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= 4'h0;
      cmd_strobe <= 1'b0;
      wr_pend    <= 1'b0;
      wr_strobe  <= 1'b0;
    end else begin
      cmd_strobe <= sclk_rise & ~ss_ff2 & (bit_cnt == 4'd7);  // 8th bit just sampled
      wr_strobe  <= ss_rise & wr_pend;
      if (ss_fall) begin
        bit_cnt <= 4'h0;
        wr_pend <= 1'b0;
      end else if (sclk_rise && !ss_ff2) begin
        bit_cnt <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd15)
          wr_pend <= ~rx_sr[14];   // read flag, about to shift into bit 15
      end else if (ss_rise) begin
        wr_pend <= 1'b0;           // consumed
      end
    end
  end

  // receive data, msb first
  always_ff @(posedge clk) begin
    if (sclk_rise && !ss_ff2)
      rx_sr <= {rx_sr[14:0], mosi_ff2};
  end

  assign cmd_byte = rx_sr[7:0];    // valid with cmd_strobe
  assign wr_addr  = rx_sr[14:8];   // valid with wr_strobe
  assign wr_data  = rx_sr[7:0];

  ////////////////////////////////////////////////////////////
  // transmit, next bit out on every sclk fall
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_sr  <= 8'h00;
      miso_q <= 1'b0;
    end else if (ss_fall) begin
      tx_sr  <= 8'h00;             // first byte answers zeros
      miso_q <= 1'b0;
    end else if (cmd_strobe) begin
      tx_sr  <= rsp_byte;          // lands before the 8th fall
    end else if (sclk_fall) begin
      miso_q <= tx_sr[7];
      tx_sr  <= {tx_sr[6:0], 1'b0};
    end
  end

  assign miso = miso_q & ~ss_n;    // quiet while deselected

endmodule

`default_nettype wire

/* design/sensor_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sensor_regs (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         cmd_strobe,
  input  wire segway_pkg::reg_byte_t  cmd_byte,   // {read flag, addr}
  input  wire                         wr_strobe,
  input  wire segway_pkg::reg_addr_t  wr_addr,
  input  wire segway_pkg::reg_byte_t  wr_data,
  input  wire segway_pkg::plat_state_t az,        // live accel z
  input  wire segway_pkg::plat_state_t ptch_rate, // live gyro pitch rate
  output segway_pkg::reg_byte_t       rsp_byte,
  output logic                        sensor_int
);

  segway_pkg::reg_byte_t regs [128];              // generic register file
  segway_pkg::reg_addr_t rd_addr;
  logic                  configured;
  logic                  clr_int;
  logic                  int_set;
  logic [segway_pkg::odr_pre_bits-1:0] pre_cnt;   // odr prescaler
  logic [segway_pkg::odr_bits-1:0]     odr_cnt;   // output data rate counter

  ////////////////////////////////////////////////////////////
  // register file, written at the end of a write frame
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 128; i++)
        regs[i] <= 8'h00;
    end else if (wr_strobe) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_addr = cmd_byte[6:0];

  // response mux, live data overrides four addresses
  always_comb begin
    if (!cmd_byte[7]) begin
      rsp_byte = segway_pkg::write_response;
    end else begin
      case (rd_addr)
        segway_pkg::addr_ptch_lo: rsp_byte = ptch_rate[7:0];
        segway_pkg::addr_ptch_hi: rsp_byte = ptch_rate[15:8];
        segway_pkg::addr_az_lo:   rsp_byte = az[7:0];
        segway_pkg::addr_az_hi:   rsp_byte = az[15:8];
        default:                  rsp_byte = regs[rd_addr];
      endcase
    end
  end

  assign clr_int = cmd_strobe & cmd_byte[7] & (rd_addr == segway_pkg::addr_ptch_lo);

  assign configured = (regs[segway_pkg::addr_cfg_a] == segway_pkg::cfg_a_value) &&
                      (regs[segway_pkg::addr_cfg_b] == segway_pkg::cfg_b_value);

  ////////////////////////////////////////////////////////////
  // odr counter and interrupt
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_cnt <= '0;
      odr_cnt <= '0;
    end else if (configured) begin
      if (pre_cnt == segway_pkg::odr_pre_last) begin
        pre_cnt <= '0;
        odr_cnt <= odr_cnt + 1'b1;   // wraps
      end else begin
        pre_cnt <= pre_cnt + 1'b1;
      end
    end
  end

  // first cycle at all ones only
  assign int_set = configured & (&odr_cnt) & (pre_cnt == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      sensor_int <= 1'b0;
    else if (clr_int)           // clear wins
      sensor_int <= 1'b0;
    else if (int_set)
      sensor_int <= 1'b1;
  end

endmodule

`default_nettype wire

/* design/pwm_duty_meter.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_duty_meter (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    pwm_frwrd,
  input  wire                    pwm_rev,
  output segway_pkg::duty_t      duty,    // fwd high time - rev high time
  output logic                   active   // either input high last cycle
);

  logic frwrd_ff, rev_ff;                 // one cycle delayed inputs
  logic rise, fall;
  segway_pkg::pwm_cnt_t frwrd_cnt, rev_cnt;
  segway_pkg::watchdog_t since_rise;      // zero duty detect

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd_ff <= 1'b0;
      rev_ff   <= 1'b0;
    end else begin
      frwrd_ff <= pwm_frwrd;
      rev_ff   <= pwm_rev;
    end
  end

  assign rise   = (pwm_frwrd & ~frwrd_ff) | (pwm_rev & ~rev_ff);
  assign fall   = (~pwm_frwrd & frwrd_ff) | (~pwm_rev & rev_ff);
  assign active = frwrd_ff | rev_ff;

  // high time counters, both restart on any rise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd_cnt <= '0;
      rev_cnt   <= '0;
    end else if (rise) begin
      frwrd_cnt <= 11'd1;
      rev_cnt   <= 11'd1;
    end else begin
      if (pwm_frwrd) frwrd_cnt <= frwrd_cnt + 1'b1;
      if (pwm_rev)   rev_cnt   <= rev_cnt + 1'b1;
    end
  end

  // time since last rise, parks at the timeout
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      since_rise <= '0;
    else if (rise)
      since_rise <= '0;
    else if (!since_rise[$bits(segway_pkg::watchdog_t)-1])
      since_rise <= since_rise + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      duty <= '0;
    else if (since_rise[$bits(segway_pkg::watchdog_t)-1])
      duty <= '0;                              // no pulses, motor idle
    else if (fall)
      duty <= {1'b0, frwrd_cnt} - {1'b0, rev_cnt};
  end

endmodule

`default_nettype wire

/* design/motor_torque.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_torque (
  input  wire segway_pkg::duty_t duty,
  output segway_pkg::torque_t    torque
);

  logic [11:0]         mag;      // |duty|, 0x800 for the most negative duty
  logic [15:0]         shaped;   // magnitude after dead zone curve
  segway_pkg::torque_t half;     // shaped / 2, positive

  assign mag = duty[11] ? 12'(-duty) : 12'(duty);

  // low gain inside the dead zone, steep slope outside
  always_comb begin
    if (mag > segway_pkg::min_duty)
      shaped = segway_pkg::torque_gain * ({4'h0, mag} - {4'h0, segway_pkg::min_duty})
               + {4'h0, segway_pkg::min_duty};
    else
      shaped = {4'h0, mag};
  end

  assign half   = {1'b0, shaped[15:1]};
  assign torque = duty[11] ? -half : half;   // restore sign

endmodule

`default_nettype wire

/* design/platform_dynamics.sv */
`timescale 1ns/1ps
`default_nettype none

module platform_dynamics (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          lft_active,
  input  wire                          rght_active,
  input  wire segway_pkg::duty_t       lft_duty,
  input  wire segway_pkg::duty_t       rght_duty,
  input  wire segway_pkg::torque_t     rider_lean,
  output segway_pkg::plat_state_t      az,
  output segway_pkg::plat_state_t      ptch_rate
);

  segway_pkg::torque_t     trq_lft, trq_rght;
  segway_pkg::torque_t     net_torque;
  segway_pkg::plat_state_t omega, theta;      // platform state
  segway_pkg::plat_state_t friction;
  segway_pkg::plat_state_t omega_nxt, theta_nxt;
  segway_pkg::watchdog_t   since_upd;         // forces periodic updates
  logic                    any_active, any_active_ff;
  logic                    last_fall;
  logic                    upd;               // physics step strobe
  logic signed [19:0]      ptch_prod;

  motor_torque u_trq_lft  (.duty(lft_duty),  .torque(trq_lft));
  motor_torque u_trq_rght (.duty(rght_duty), .torque(trq_rght));

  ////////////////////////////////////////////////////////////
  // update trigger
  ////////////////////////////////////////////////////////////
  assign any_active = lft_active | rght_active;
  assign last_fall  = ~any_active & any_active_ff;   // last pwm just ended

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      any_active_ff <= 1'b0;
      upd           <= 1'b0;
      since_upd     <= '0;
    end else begin
      any_active_ff <= any_active;
      upd           <= last_fall | since_upd[$bits(segway_pkg::watchdog_t)-1];
      if (upd || since_upd[$bits(segway_pkg::watchdog_t)-1])
        since_upd <= '0;
      else
        since_upd <= since_upd + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // integrators, 16 bit wrapping
  ////////////////////////////////////////////////////////////
  assign net_torque = rider_lean - trq_lft - trq_rght;

  // friction grows with speed, minimum of one count
  assign friction = (|omega[15:10]) ? (omega >>> 10) :
                    (|omega)        ? 16'sd1 : 16'sd0;

  assign omega_nxt = omega - (net_torque >>> 3) - friction;
  assign theta_nxt = theta - (omega_nxt >>> 6);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      omega <= '0;
      theta <= '0;
    end else if (upd) begin
      omega <= omega_nxt;
      theta <= theta_nxt;
    end
  end

  // sensor views of the state
  assign az        = (theta >>> 3) + segway_pkg::az_offset;
  assign ptch_prod = omega * segway_pkg::ptch_rate_scale;   // 12/16 gyro gain
  assign ptch_rate = ptch_prod[19:4] + segway_pkg::ptch_rt_offset;

endmodule

`default_nettype wire

/* design/segway_sensor_top.sv */
`timescale 1ns/1ps
`default_nettype none

module segway_sensor_top (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      ss_n,
  input  wire                      sclk,
  input  wire                      mosi,
  input  wire                      pwm_frwrd_lft,
  input  wire                      pwm_rev_lft,
  input  wire                      pwm_frwrd_rght,
  input  wire                      pwm_rev_rght,
  input  wire segway_pkg::torque_t rider_lean,   // positive leans forward
  output logic                     miso,
  output logic                     sensor_int    // data ready
);

  // spi port <-> register block
  logic                    cmd_strobe;
  segway_pkg::reg_byte_t   cmd_byte;
  segway_pkg::reg_byte_t   rsp_byte;
  logic                    wr_strobe;
  segway_pkg::reg_addr_t   wr_addr;
  segway_pkg::reg_byte_t   wr_data;

  // motors -> physics -> sensor
  segway_pkg::duty_t       lft_duty, rght_duty;
  logic                    lft_active, rght_active;
  segway_pkg::plat_state_t az, ptch_rate;

  spi_slave_port u_spi (
    .clk(clk), .rst_n(rst_n), .ss_n(ss_n), .sclk(sclk), .mosi(mosi),
    .rsp_byte(rsp_byte), .miso(miso), .cmd_strobe(cmd_strobe), .cmd_byte(cmd_byte),
    .wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  sensor_regs u_regs (
    .clk(clk), .rst_n(rst_n), .cmd_strobe(cmd_strobe), .cmd_byte(cmd_byte),
    .wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_data(wr_data),
    .az(az), .ptch_rate(ptch_rate), .rsp_byte(rsp_byte), .sensor_int(sensor_int)
  );

  pwm_duty_meter u_pwm_lft (
    .clk(clk), .rst_n(rst_n), .pwm_frwrd(pwm_frwrd_lft), .pwm_rev(pwm_rev_lft),
    .duty(lft_duty), .active(lft_active)
  );

  pwm_duty_meter u_pwm_rght (
    .clk(clk), .rst_n(rst_n), .pwm_frwrd(pwm_frwrd_rght), .pwm_rev(pwm_rev_rght),
    .duty(rght_duty), .active(rght_active)
  );

  platform_dynamics u_dyn (
    .clk(clk), .rst_n(rst_n), .lft_active(lft_active), .rght_active(rght_active),
    .lft_duty(lft_duty), .rght_duty(rght_duty), .rider_lean(rider_lean),
    .az(az), .ptch_rate(ptch_rate)
  );

endmodule

`default_nettype wire

/* verification/tb_segway_model.svh */
`ifndef TB_SEGWAY_MODEL_SVH
`define TB_SEGWAY_MODEL_SVH
`default_nettype none

// model state, follows the dut one physics step at a time
logic [31:0]        rng_state;
logic [7:0]         model_regs [128];   // generic register file
logic signed [15:0] m_omega;
logic signed [15:0] m_theta;

// xorshift32 random source
function automatic logic [31:0] next_rand();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

task automatic model_reset();
  int i;
  for (i = 0; i < 128; i++)
    model_regs[i] = 8'h00;
  m_omega   = '0;
  m_theta   = '0;
  rng_state = 32'd70;   // fixed seed
endtask

////////////////////////////////////////////////////////////
// dead zone torque curve, half of the shaped magnitude
////////////////////////////////////////////////////////////
function automatic logic signed [15:0] expected_torque(input int duty);
  int mag;
  int shaped;
  int dz;
  dz  = int'(segway_pkg::min_duty);
  mag = (duty < 0) ? -duty : duty;
  if (mag > dz)
    shaped = 14 * (mag - dz) + dz;   // steep past the dead zone
  else
    shaped = mag;
  return (duty < 0) ? 16'(-(shaped / 2)) : 16'(shaped / 2);
endfunction

// one platform update, all 16 bit wrapping
task automatic model_step(input int duty_l, input int duty_r, input logic signed [15:0] lean);
  logic signed [15:0] net;
  logic signed [15:0] fric;
  logic signed [15:0] om_new;
  net = lean - expected_torque(duty_l) - expected_torque(duty_r);
  if (m_omega[15:10] != 6'h00)
    fric = m_omega >>> 10;
  else if (m_omega != 16'sd0)
    fric = 16'sd1;                    // minimum friction
  else
    fric = 16'sd0;
  om_new  = m_omega - (net >>> 3) - fric;
  m_theta = m_theta - (om_new >>> 6);
  m_omega = om_new;
endtask

function automatic logic [15:0] model_az();
  return 16'((int'(m_theta) >>> 3) + int'(segway_pkg::az_offset));
endfunction

function automatic logic [15:0] model_ptch();
  int p;
  p = int'(m_omega) * 12;             // gain 12/16
  return 16'((p >>> 4) + int'(segway_pkg::ptch_rt_offset));
endfunction

// expected byte on miso for a read of addr
function automatic logic [7:0] expected_read(input logic [6:0] addr);
  logic [15:0] a;
  logic [15:0] p;
  a = model_az();
  p = model_ptch();
  case (addr)
    segway_pkg::addr_ptch_lo: return p[7:0];
    segway_pkg::addr_ptch_hi: return p[15:8];
    segway_pkg::addr_az_lo:   return a[7:0];
    segway_pkg::addr_az_hi:   return a[15:8];
    default:                  return model_regs[addr];
  endcase
endfunction

`default_nettype wire
`endif

/* verification/tb_segway_sensor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_segway_sensor;

  logic                clk;
  logic                rst_n;
  logic                ss_n, sclk, mosi;
  logic                pwm_frwrd_lft, pwm_rev_lft;
  logic                pwm_frwrd_rght, pwm_rev_rght;
  segway_pkg::torque_t rider_lean;
  logic                miso;
  logic                sensor_int;
  logic [6:0]          wr_addrs [12];   // addresses hit by the write test

  `include "tb_segway_model.svh"

  segway_sensor_top UUT (
    .clk(clk), .rst_n(rst_n), .ss_n(ss_n), .sclk(sclk), .mosi(mosi),
    .pwm_frwrd_lft(pwm_frwrd_lft), .pwm_rev_lft(pwm_rev_lft),
    .pwm_frwrd_rght(pwm_frwrd_rght), .pwm_rev_rght(pwm_rev_rght),
    .rider_lean(rider_lean), .miso(miso), .sensor_int(sensor_int)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  task automatic tick(input int n);
    repeat (n) @(negedge clk);   // inputs change on falling edge
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // mode 0 frame, msb first, half period of 4 clk
  task automatic spi_frame(input segway_pkg::spi_word_t word, output segway_pkg::reg_byte_t rsp);
    int i;
    rsp  = 8'h00;
    ss_n = 1'b0;
    tick(2);
    for (i = 15; i >= 0; i--) begin
      mosi = word[i];
      tick(4);
      if (i < 8)
        rsp[i] = miso;   // second byte carries the response
      sclk = 1'b1;
      tick(4);
      sclk = 1'b0;
    end
    tick(2);
    ss_n = 1'b1;
    mosi = 1'b0;
    tick(6);             // write commits after ss_n rise
  endtask

  task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
    segway_pkg::reg_byte_t rsp;
    spi_frame({1'b0, addr, data}, rsp);
    check_value("miso write response", rsp, segway_pkg::write_response);
    model_regs[addr] = data;
  endtask

  task automatic read_check(input logic [6:0] addr);
    segway_pkg::reg_byte_t rsp;
    spi_frame({1'b1, addr, 8'h00}, rsp);
    check_value($sformatf("miso read 0x%02h", addr), rsp, expected_read(addr));
  endtask

  task automatic hold_int_low(input int n);
    repeat (n) begin
      tick(1);
      check_value("sensor_int", sensor_int, 0);
    end
  endtask

  task automatic wait_int(input logic level, input int limit);
    int c;
    c = 0;
    while (sensor_int !== level && c < limit) begin
      tick(1);
      c++;
    end
    if (sensor_int !== level)
      abort_run("timeout waiting for sensor_int to change");
  endtask

  // both motors start together, then one physics step and a sensor readout
  task automatic run_pwm_period(input int w_l, input logic rev_l, input int w_r,
                                input logic rev_r, input logic signed [15:0] lean);
    int t;
    int w_max;
    int duty_l;
    int duty_r;
    w_max  = (w_l > w_r) ? w_l : w_r;
    duty_l = rev_l ? 1 - w_l : w_l - 1;   // w high cycles read as w-1
    duty_r = rev_r ? 1 - w_r : w_r - 1;
    rider_lean     = lean;
    pwm_frwrd_lft  = ~rev_l;
    pwm_rev_lft    = rev_l;
    pwm_frwrd_rght = ~rev_r;
    pwm_rev_rght   = rev_r;
    for (t = 1; t <= w_max; t++) begin
      tick(1);
      if (t == w_l) begin
        pwm_frwrd_lft = 1'b0;
        pwm_rev_lft   = 1'b0;
      end
      if (t == w_r) begin
        pwm_frwrd_rght = 1'b0;
        pwm_rev_rght   = 1'b0;
      end
    end
    tick(4);   // strobe after last fall, state a cycle later
    model_step(duty_l, duty_r, lean);
    read_check(segway_pkg::addr_az_lo);
    read_check(segway_pkg::addr_az_hi);
    read_check(segway_pkg::addr_ptch_lo);
    read_check(segway_pkg::addr_ptch_hi);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int          i;
    int          w_l;
    int          w_r;
    logic [31:0] r;
    logic [6:0]  addr;
    logic signed [15:0] lean;
    rst_n          = 1'b0;
    ss_n           = 1'b1;
    sclk           = 1'b0;
    mosi           = 1'b0;
    pwm_frwrd_lft  = 1'b0;
    pwm_rev_lft    = 1'b0;
    pwm_frwrd_rght = 1'b0;
    pwm_rev_rght   = 1'b0;
    rider_lean     = '0;
    model_reset();
    tick(16);
    rst_n = 1'b1;
    tick(4);

    // live values straight out of reset
    read_check(segway_pkg::addr_az_lo);
    read_check(segway_pkg::addr_az_hi);
    read_check(segway_pkg::addr_ptch_lo);
    read_check(segway_pkg::addr_ptch_hi);

    // generic registers, live and cfg addresses folded away
    for (i = 0; i < 12; i++) begin
      r    = next_rand();
      addr = r[6:0];
      if (addr == 7'h22 || addr == 7'h23 || addr == 7'h2C || addr == 7'h2D ||
          addr == 7'h0D || addr == 7'h11)
        addr = addr ^ 7'h40;
      wr_addrs[i] = addr;
      spi_write(addr, r[15:8]);
    end
    for (i = 0; i < 12; i++)
      read_check(wr_addrs[i]);

    // int gated until both cfg registers match
    hold_int_low(5000);
    spi_write(segway_pkg::addr_cfg_a, segway_pkg::cfg_a_value);
    hold_int_low(9000);   // longer than one full odr wrap of 8192 clk
    spi_write(segway_pkg::addr_cfg_b, segway_pkg::cfg_b_value);
    wait_int(1'b1, 20000);

    // only the pitch rate low byte clears int
    read_check(segway_pkg::addr_ptch_hi);
    check_value("sensor_int", sensor_int, 1);
    read_check(segway_pkg::addr_ptch_lo);
    check_value("sensor_int", sensor_int, 0);
    wait_int(1'b1, 20000);   // back on next wrap

    // zero duty pulse lines up the update watchdog
    run_pwm_period(1, 1'b0, 1, 1'b0, 16'sd0);
    for (i = 0; i < 40; i++) begin
      r    = next_rand();
      w_l  = 1 + int'(r % 1200);
      r    = next_rand();
      w_r  = 1 + int'(r % 1200);
      r    = next_rand();
      lean = 16'(int'(r % 2047) - 1023);   // |lean| < 0x400
      run_pwm_period(w_l, r[31], w_r, r[30], lean);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verification
design/segway_pkg.sv
design/spi_slave_port.sv
design/sensor_regs.sv
design/pwm_duty_meter.sv
design/motor_torque.sv
design/platform_dynamics.sv
design/segway_sensor_top.sv
verification/tb_segway_sensor.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench; exit status is the simulation result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module tb_segway_sensor \
  -f list.f \
  -o tb_segway_sensor

./obj_dir/tb_segway_sensor
